// File: flist.f
+incdir+src
src/disp_pkg.sv
src/draw_pkg.sv
src/pix_wr_if.sv
src/display_timings.sv
src/draw_line.sv
src/draw_triangle.sv
src/shape_sequencer.sv
src/framebuffer.sv
src/triangles_top.sv
verif/tb_triangles.sv

// File: src/disp_pkg.sv
// Display side types
// screen coordinates and the scan position bundle from the timing generator
package disp_pkg;

    typedef logic signed [7:0] scr_coord_t;  // covers 0..39 raster

    // one scan position with its sync and strobe flags
    typedef struct packed {
        scr_coord_t sx;     // horizontal position
        scr_coord_t sy;     // vertical position
        logic       hsync;  // positive polarity
        logic       vsync;  // positive polarity
        logic       de;     // inside active area
        logic       frame;  // first pixel of frame
        logic       line;   // first pixel of line
    } scan_t;

endpackage

// File: src/display_timings.sv
// Display timing generator
// free-running raster counters with syncs, data enable and frame/line strobes
`include "gfx_params.svh"

module display_timings (
    input  logic            clk_pix,
    input  logic            rst_n,
    output disp_pkg::scan_t scan
);

    localparam disp_pkg::scr_coord_t H_LAST = `GFX_H_TOTAL - 1;
    localparam disp_pkg::scr_coord_t V_LAST = `GFX_V_TOTAL - 1;

    disp_pkg::scr_coord_t sx;
    disp_pkg::scr_coord_t sy;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_LAST) begin  // end of line
            sx <= '0;
            sy <= (sy == V_LAST) ? '0 : sy + 1'b1;  // wrap at frame end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    always_comb begin
        scan.sx    = sx;
        scan.sy    = sy;
        scan.hsync = (sx >= `GFX_H_SYNC_START) && (sx < `GFX_H_SYNC_END);
        scan.vsync = (sy >= `GFX_V_SYNC_START) && (sy < `GFX_V_SYNC_END);
        scan.de    = (sx < `GFX_H_ACTIVE) && (sy < `GFX_V_ACTIVE);
        scan.frame = (sx == 0) && (sy == 0);
        scan.line  = (sx == 0);
    end

    // horizontal counter stays inside the raster
    sx_in_range: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        sx < `GFX_H_TOTAL
    );

endmodule

// File: src/draw_line.sv
// Line drawer
// integer error-term tracer, all octants, one pixel per accepted step
module draw_line (
    input  logic              clk_pix,
    input  logic              rst_n,
    input  logic              start,
    input  logic              step_ok,    // write slot available
    input  draw_pkg::vertex_t p0,
    input  draw_pkg::vertex_t p1,
    output draw_pkg::vertex_t pix,
    output logic              pix_valid,
    output logic              done
);

    typedef enum logic {IDLE, DRAW} state_t;
    state_t state;

    draw_pkg::fb_coord_t x_end;
    draw_pkg::fb_coord_t y_end;
    logic signed [9:0]   dx;       // abs x distance
    logic signed [9:0]   dy;       // abs y distance
    logic signed [9:0]   err;
    logic signed [9:0]   e2;
    logic signed [9:0]   dx_new;
    logic signed [9:0]   dy_new;
    logic                x_neg;    // step direction
    logic                y_neg;
    logic                move_x;
    logic                move_y;
    logic                at_end;

    always_comb begin
        dx_new    = 10'(p1.x) - 10'(p0.x);
        dy_new    = 10'(p1.y) - 10'(p0.y);
        e2        = err <<< 1;
        move_x    = (e2 >= -dy);
        move_y    = (e2 <= dx);
        at_end    = (pix.x == x_end) && (pix.y == y_end);
        pix_valid = (state == DRAW) && step_ok;  // current pixel goes out
    end

    // datapath
    always_ff @(posedge clk_pix) begin
        if (state == IDLE && start) begin
            pix   <= p0;
            x_end <= p1.x;
            y_end <= p1.y;
            x_neg <= dx_new < 0;
            y_neg <= dy_new < 0;
            dx    <= (dx_new < 0) ? -dx_new : dx_new;
            dy    <= (dy_new < 0) ? -dy_new : dy_new;
            err   <= ((dx_new < 0) ? -dx_new : dx_new) - ((dy_new < 0) ? -dy_new : dy_new);
        end else if (pix_valid && !at_end) begin
            if (move_x) pix.x <= x_neg ? pix.x - 1'b1 : pix.x + 1'b1;
            if (move_y) pix.y <= y_neg ? pix.y - 1'b1 : pix.y + 1'b1;
            err <= err - (move_x ? dy : 10'sd0) + (move_y ? dx : 10'sd0);
        end
    end

    // control
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: if (start) state <= DRAW;
                DRAW: begin
                    if (pix_valid && at_end) begin  // last pixel accepted
                        state <= IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: src/draw_pkg.sv
// Drawing side types
// framebuffer coordinates, triangles, colours and the fixed tables
`include "gfx_params.svh"

package draw_pkg;

    typedef logic signed [5:0] fb_coord_t;  // -32..31, fb is 16x12
    typedef logic [`GFX_FB_CIDXW-1:0] cidx_t;

    typedef struct packed {
        fb_coord_t x;
        fb_coord_t y;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
        cidx_t   cidx;  // outline colour
    } tri_t;

    typedef struct packed {
        logic [`GFX_CHANW-1:0] red;
        logic [`GFX_CHANW-1:0] green;
        logic [`GFX_CHANW-1:0] blue;
    } rgb_t;

    // 4-entry palette indexed by cidx
    localparam rgb_t PALETTE [2**`GFX_FB_CIDXW] = '{
        '{4'h0, 4'h0, 4'h0},  // black
        '{4'hF, 4'h8, 4'h0},  // orange
        '{4'h0, 4'hC, 4'h4},  // green
        '{4'h4, 4'h8, 4'hF}   // blue
    };

    // triangles drawn in table order, later ones on top
    localparam tri_t SHAPES [3] = '{
        '{'{6'sd2, 6'sd1}, '{6'sd14, 6'sd4}, '{6'sd8, 6'sd10}, 2'd1},
        '{'{6'sd3, 6'sd10}, '{6'sd11, 6'sd5}, '{6'sd8, 6'sd0}, 2'd2},
        '{'{6'sd1, 6'sd2}, '{6'sd3, 6'sd9}, '{6'sd6, 6'sd6}, 2'd3}
    };

endpackage

// File: src/draw_triangle.sv
// Triangle outline rasterizer
// traces three edges through one line drawer, paced by write credits
`include "gfx_params.svh"

module draw_triangle (
    input  logic           clk_pix,
    input  logic           rst_n,
    input  logic           start,
    input  draw_pkg::tri_t tri_def,
    pix_wr_if.drawer       wr,
    output logic           busy,
    output logic           done
);

    localparam int CW = $clog2(`GFX_WR_CREDITS + 1);

    typedef enum logic {IDLE, RUN} state_t;
    state_t state;

    draw_pkg::tri_t    tri_q;       // triangle being traced
    logic [1:0]        edge_idx;    // 0: v0-v1, 1: v1-v2, 2: v2-v0
    logic              line_start;
    logic              line_done;
    draw_pkg::vertex_t p0;
    draw_pkg::vertex_t p1;
    draw_pkg::vertex_t pix;
    logic              pix_valid;
    logic [CW-1:0]     credits;     // free slots in fb queue

    always_comb begin
        case (edge_idx)
            2'd0:    begin p0 = tri_q.v0; p1 = tri_q.v1; end
            2'd1:    begin p0 = tri_q.v1; p1 = tri_q.v2; end
            default: begin p0 = tri_q.v2; p1 = tri_q.v0; end
        endcase
    end

    draw_line u_line (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .start     (line_start),
        .step_ok   (credits != '0),
        .p0        (p0),
        .p1        (p1),
        .pix       (pix),
        .pix_valid (pix_valid),
        .done      (line_done)
    );

    always_ff @(posedge clk_pix) begin
        if (state == IDLE && start) tri_q <= tri_def;
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            edge_idx   <= '0;
            line_start <= 1'b0;
            done       <= 1'b0;
        end else begin
            line_start <= 1'b0;
            done       <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state      <= RUN;
                        edge_idx   <= '0;
                        line_start <= 1'b1;
                    end
                end
                RUN: begin
                    if (line_done) begin
                        if (edge_idx == 2'd2) begin  // last edge traced
                            state <= IDLE;
                            done  <= 1'b1;
                        end else begin
                            edge_idx   <= edge_idx + 1'b1;
                            line_start <= 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // spend on write, refill on fb commit
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) credits <= CW'(`GFX_WR_CREDITS);
        else credits <= credits - CW'(wr.valid) + CW'(wr.credit);
    end

    assign busy     = (state != IDLE);
    assign wr.valid = pix_valid;
    assign wr.x     = pix.x;
    assign wr.y     = pix.y;
    assign wr.cidx  = tri_q.cidx;

    no_write_without_credit: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        wr.valid |-> (credits != '0)
    );

    credit_bound: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        credits <= `GFX_WR_CREDITS
    );

endmodule

// File: src/framebuffer.sv
// Indexed-colour framebuffer
// clear sweep, credited write queue, scaled display read and palette output
`include "gfx_params.svh"

module framebuffer (
    input  logic            clk_pix,
    input  logic            rst_n,
    input  disp_pkg::scan_t scan,
    pix_wr_if.fb            wr,
    output draw_pkg::rgb_t  rgb,
    output logic            de,
    output logic            hsync,
    output logic            vsync
);

    localparam int FB_W  = `GFX_FB_WIDTH;
    localparam int FB_H  = `GFX_FB_HEIGHT;
    localparam int DEPTH = FB_W * FB_H;
    localparam int AW    = $clog2(DEPTH);
    localparam int QD    = `GFX_WR_CREDITS;
    localparam int QPW   = $clog2(QD);

    draw_pkg::cidx_t mem [DEPTH];  // colour index memory

    logic [AW-1:0]   q_addr [QD];  // write queue
    draw_pkg::cidx_t q_cidx [QD];
    logic            q_inb [QD];   // inside fb, else dropped on commit
    logic [QPW-1:0]  wr_ptr;
    logic [QPW-1:0]  rd_ptr;
    logic [QPW:0]    q_count;
    logic            clearing;
    logic [AW-1:0]   clr_addr;
    logic            commit;
    logic            wr_inb;
    logic            show;
    logic [AW-1:0]   wr_addr;
    logic [AW-1:0]   rd_addr;
    draw_pkg::cidx_t rd_cidx;

    always_comb begin
        wr_inb  = (wr.x >= 0) && (wr.x < FB_W) && (wr.y >= 0) && (wr.y < FB_H);
        wr_addr = AW'($unsigned(wr.y)) * AW'(FB_W) + AW'($unsigned(wr.x));
        rd_addr = AW'(scan.sy / `GFX_FB_SCALE) * AW'(FB_W) + AW'(scan.sx / `GFX_FB_SCALE);
        commit  = !clearing && (q_count != '0) && !scan.de;  // blanking only
        show    = scan.de && !clearing;
        rd_cidx = mem[rd_addr];
    end

    always_ff @(posedge clk_pix) begin
        if (wr.valid) begin
            q_addr[wr_ptr] <= wr_addr;
            q_cidx[wr_ptr] <= wr.cidx;
            q_inb[wr_ptr]  <= wr_inb;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (clearing) mem[clr_addr] <= '0;  // sweep to black
        else if (commit && q_inb[rd_ptr]) mem[q_addr[rd_ptr]] <= q_cidx[rd_ptr];
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            clearing  <= 1'b1;
            clr_addr  <= '0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            q_count   <= '0;
            wr.credit <= 1'b0;
        end else begin
            if (clearing) begin
                clr_addr <= clr_addr + 1'b1;
                if (clr_addr == AW'(DEPTH - 1)) clearing <= 1'b0;
            end
            if (wr.valid) wr_ptr <= wr_ptr + 1'b1;
            if (commit) rd_ptr <= rd_ptr + 1'b1;
            q_count   <= q_count + (QPW+1)'(wr.valid) - (QPW+1)'(commit);
            wr.credit <= commit;  // slot freed
        end
    end

    // output stage, one cycle behind the scan position
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            rgb   <= '0;
            de    <= 1'b0;
            hsync <= 1'b0;
            vsync <= 1'b0;
        end else begin
            rgb   <= show ? draw_pkg::PALETTE[rd_cidx] : '0;
            de    <= show;
            hsync <= scan.hsync;
            vsync <= scan.vsync;
        end
    end

    queue_no_overflow: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        wr.valid |-> (q_count != QD)
    );

endmodule

// File: src/gfx_params.svh
// Graphics subsystem sizes
// raster timing, framebuffer geometry, colour widths and write credits
`ifndef GFX_PARAMS_SVH
`define GFX_PARAMS_SVH

`define GFX_H_ACTIVE      32  // visible pixels per line
`define GFX_H_TOTAL       40  // pixels per line incl. blanking
`define GFX_H_SYNC_START  34
`define GFX_H_SYNC_END    37  // exclusive
`define GFX_V_ACTIVE      24  // visible lines per frame
`define GFX_V_TOTAL       30
`define GFX_V_SYNC_START  25
`define GFX_V_SYNC_END    27  // exclusive

`define GFX_FB_WIDTH      16
`define GFX_FB_HEIGHT     12
`define GFX_FB_SCALE      2   // fb pixel covers 2x2 screen pixels
`define GFX_FB_CIDXW      2   // colour index bits
`define GFX_CHANW         4   // bits per colour channel
`define GFX_WR_CREDITS    4   // write queue depth

`endif

// File: src/pix_wr_if.sv
// Pixel write channel between triangle drawer and framebuffer
// credit pulses once per write committed to memory
interface pix_wr_if;

    logic                valid;   // one pixel write, costs one credit
    draw_pkg::fb_coord_t x;
    draw_pkg::fb_coord_t y;
    draw_pkg::cidx_t     cidx;
    logic                credit;  // slot freed in fb queue

    modport drawer (
        output valid, x, y, cidx,
        input  credit
    );

    modport fb (
        input  valid, x, y, cidx,
        output credit
    );

endinterface

// File: src/shape_sequencer.sv
// Shape sequencer
// walks the fixed triangle table once per draw request
module shape_sequencer (
    input  logic           clk_pix,
    input  logic           rst_n,
    input  logic           draw_go,
    output logic           tri_start,
    output draw_pkg::tri_t tri_def,
    input  logic           tri_done,
    output logic           draw_done
);

    localparam int SHAPE_CNT = $size(draw_pkg::SHAPES);

    typedef enum logic [1:0] {IDLE, LOAD, DRAW, FINISH} state_t;
    state_t state;

    logic [1:0] shape_id;

    always_ff @(posedge clk_pix) begin
        if (state == LOAD) tri_def <= draw_pkg::SHAPES[shape_id];  // next entry
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            shape_id  <= '0;
            tri_start <= 1'b0;
            draw_done <= 1'b0;
        end else begin
            tri_start <= 1'b0;
            draw_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (draw_go) begin  // only honoured here
                        state    <= LOAD;
                        shape_id <= '0;
                    end
                end
                LOAD: begin
                    state     <= DRAW;
                    tri_start <= 1'b1;  // entry registered this cycle
                end
                DRAW: begin
                    if (tri_done) begin
                        if (shape_id == 2'(SHAPE_CNT - 1)) begin
                            state <= FINISH;
                        end else begin
                            shape_id <= shape_id + 1'b1;
                            state    <= LOAD;
                        end
                    end
                end
                FINISH: begin
                    state     <= IDLE;
                    draw_done <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: src/triangles_top.sv
// Triangle drawing top level
// draws the shape table into the framebuffer and scans it out as video
`include "gfx_params.svh"

module triangles_top (
    input  logic                  clk_pix,
    input  logic                  rst_n,
    input  logic                  draw_go,
    output logic                  draw_done,
    output logic                  de,
    output logic                  hsync,
    output logic                  vsync,
    output logic [`GFX_CHANW-1:0] r,
    output logic [`GFX_CHANW-1:0] g,
    output logic [`GFX_CHANW-1:0] b
);

    disp_pkg::scan_t scan;       // raster position and flags
    draw_pkg::tri_t  tri_def;    // current triangle
    draw_pkg::rgb_t  rgb;
    logic            tri_start;
    logic            tri_done;

    pix_wr_if pix_wr ();         // drawer to fb writes

    display_timings u_timings (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .scan    (scan)
    );

    shape_sequencer u_seq (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .draw_go   (draw_go),
        .tri_start (tri_start),
        .tri_def   (tri_def),
        .tri_done  (tri_done),
        .draw_done (draw_done)
    );

    draw_triangle u_tri (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .start   (tri_start),
        .tri_def (tri_def),
        .wr      (pix_wr.drawer),
        .busy    (),
        .done    (tri_done)
    );

    framebuffer u_fb (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .scan    (scan),
        .wr      (pix_wr.fb),
        .rgb     (rgb),
        .de      (de),
        .hsync   (hsync),
        .vsync   (vsync)
    );

    assign r = rgb.red;
    assign g = rgb.green;
    assign b = rgb.blue;

endmodule

// File: verif/tb_triangles.sv
// Triangle subsystem testbench
// directed tests of reset, raster timing, clear and drawing against a reference image
module tb_triangles;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int H_ACT        = 32;
    localparam int H_TOTAL      = 40;
    localparam int HS_LEN       = 3;   // 34..36
    localparam int V_ACT        = 24;
    localparam int V_TOTAL      = 30;
    localparam int VS_START     = 25;
    localparam int VS_END       = 27;  // exclusive
    localparam int FB_W         = 16;
    localparam int FB_H         = 12;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int RESET_CYCLES = 16;
    localparam int CYCLE_LIMIT  = 20 * FRAME_CYCLES + RESET_CYCLES;

    logic       clk_pix;
    logic       rst_n;
    logic       draw_go;
    logic       draw_done;
    logic       de;
    logic       hsync;
    logic       vsync;
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;

    logic [1:0]  model [FB_H][FB_W];  // expected colour indices
    logic [15:0] lfsr_state;
    int          done_count;
    int          cycle_count;

    triangles_top u_dut (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .draw_go   (draw_go),
        .draw_done (draw_done),
        .de        (de),
        .hsync     (hsync),
        .vsync     (vsync),
        .r         (r),
        .g         (g),
        .b         (b)
    );

    initial begin
        clk_pix = 1'b0;
        forever #2 clk_pix = ~clk_pix;  // 4 ns period
    end

    always @(negedge clk_pix) begin
        if (rst_n && draw_done) done_count++;  // pulses seen
    end

    always @(posedge clk_pix) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run exceeded %0d cycles without finishing", CYCLE_LIMIT);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_next_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [11:0] palette_rgb(input logic [1:0] cidx);
        case (cidx)
            2'd1:    return 12'hF80;  // orange
            2'd2:    return 12'h0C4;  // green
            2'd3:    return 12'h48F;  // blue
            default: return 12'h000;
        endcase
    endfunction

    // error-term tracer, both endpoints inclusive
    task automatic trace_edge(input int x0, input int y0, input int x1, input int y1,
                              input logic [1:0] c);
        int x;
        int y;
        int dx;
        int dy;
        int err;
        int e2;
        bit last;
        x    = x0;
        y    = y0;
        dx   = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy   = (y1 > y0) ? y1 - y0 : y0 - y1;
        err  = dx - dy;
        last = 1'b0;
        while (!last) begin
            if (x >= 0 && x < FB_W && y >= 0 && y < FB_H) model[y][x] = c;
            last = (x == x1) && (y == y1);
            e2   = 2 * err;
            if (!last && e2 >= -dy) begin
                err -= dy;
                x   += (x1 >= x0) ? 1 : -1;
            end
            if (!last && e2 <= dx) begin
                err += dx;
                y   += (y1 >= y0) ? 1 : -1;
            end
        end
    endtask

    task automatic build_model();
        draw_pkg::tri_t t;
        foreach (model[y, x]) model[y][x] = 2'd0;
        for (int s = 0; s < 3; s++) begin  // table order, later on top
            t = draw_pkg::SHAPES[s];
            trace_edge(int'(t.v0.x), int'(t.v0.y), int'(t.v1.x), int'(t.v1.y), t.cidx);
            trace_edge(int'(t.v1.x), int'(t.v1.y), int'(t.v2.x), int'(t.v2.y), t.cidx);
            trace_edge(int'(t.v2.x), int'(t.v2.y), int'(t.v0.x), int'(t.v0.y), t.cidx);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_pix);
    endtask

    task automatic random_gap();
        int n;
        n = 0;
        repeat (4) n = (n << 1) | int'(lfsr_next_bit());
        wait_cycles(n + 1);
    endtask

    task automatic pulse_draw_go();
        @(posedge clk_pix);
        #1 draw_go = 1'b1;
        @(posedge clk_pix);
        #1 draw_go = 1'b0;
    endtask

    task automatic wait_draw_done(input int start_count);
        while (done_count == start_count) @(posedge clk_pix);
    endtask

    // returns at the negedge showing (0, VS_END), first line after vsync
    task automatic sync_to_frame();
        @(negedge clk_pix);
        while (!vsync) @(negedge clk_pix);
        while (vsync) @(negedge clk_pix);
    endtask

    task automatic check_outputs_idle(input string when);
        check_value(de, 0, {"de ", when});
        check_value(hsync, 0, {"hsync ", when});
        check_value(vsync, 0, {"vsync ", when});
        check_value({r, g, b}, 0, {"rgb ", when});
    endtask

    task automatic check_frame(input bit use_model);
        int sx;
        int sy;
        logic [11:0] exp_rgb;
        sync_to_frame();
        for (int k = 0; k < FRAME_CYCLES; k++) begin
            if (k > 0) @(negedge clk_pix);
            sx = k % H_TOTAL;
            sy = (VS_END + k / H_TOTAL) % V_TOTAL;
            check_value(de, (sx < H_ACT) && (sy < V_ACT), $sformatf("de at (%0d,%0d)", sx, sy));
            if (de) begin
                exp_rgb = use_model ? palette_rgb(model[sy / 2][sx / 2]) : 12'h000;
                check_value({r, g, b}, exp_rgb, $sformatf("colour at (%0d,%0d)", sx, sy));
            end
        end
    endtask

    task automatic test_reset();
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk_pix);
            check_outputs_idle("during reset");
        end
        @(posedge clk_pix);
        #1 rst_n = 1'b1;
        @(posedge clk_pix);  // first registered cycle
        @(negedge clk_pix);
        check_outputs_idle("after reset");
    endtask

    task automatic test_timing();
        int de_cnt;
        int hs_cnt;
        int vs_cnt;
        int sy;
        int de_lines;
        int vs_lines;
        de_lines = 0;
        vs_lines = 0;
        sync_to_frame();
        for (int ln = 0; ln < V_TOTAL; ln++) begin
            de_cnt = 0;
            hs_cnt = 0;
            vs_cnt = 0;
            for (int px = 0; px < H_TOTAL; px++) begin
                if (ln > 0 || px > 0) @(negedge clk_pix);
                de_cnt += int'(de);
                hs_cnt += int'(hsync);
                vs_cnt += int'(vsync);
            end
            sy = (VS_END + ln) % V_TOTAL;
            check_value(de_cnt, (sy < V_ACT) ? H_ACT : 0, $sformatf("de count line %0d", sy));
            check_value(hs_cnt, HS_LEN, $sformatf("hsync count line %0d", sy));
            check_value(vs_cnt, (sy >= VS_START && sy < VS_END) ? H_TOTAL : 0,
                        $sformatf("vsync count line %0d", sy));
            if (de_cnt != 0) de_lines++;
            if (vs_cnt != 0) vs_lines++;
        end
        check_value(de_lines, V_ACT, "lines with de");
        check_value(vs_lines, VS_END - VS_START, "lines with vsync");
    endtask

    task automatic test_blank();
        wait_cycles(FRAME_CYCLES);  // clear sweep done by now
        check_frame(1'b0);
    endtask

    task automatic test_draw();
        int start_count;
        random_gap();
        start_count = done_count;
        pulse_draw_go();
        wait_draw_done(start_count);
        wait_cycles(FRAME_CYCLES);  // queued writes drain in blanking
        check_value(done_count, start_count + 1, "draw_done pulses");
        check_frame(1'b1);
    endtask

    task automatic test_redraw_ignore();
        int start_count;
        random_gap();
        start_count = done_count;
        pulse_draw_go();
        repeat (3) begin
            wait_cycles(5);
            check_value(done_count, start_count, "draw still running");
            pulse_draw_go();  // should be ignored
        end
        wait_draw_done(start_count);
        wait_cycles(FRAME_CYCLES);
        check_value(done_count, start_count + 1, "single draw_done on redraw");
        check_frame(1'b1);
    endtask

    initial begin
        rst_n       = 1'b0;
        draw_go     = 1'b0;
        lfsr_state  = 16'd72;
        done_count  = 0;
        cycle_count = 0;
        build_model();
        test_reset();
        test_timing();
        test_blank();
        test_draw();
        test_redraw_ignore();
        $display("Simulation passed");
        $finish;
    end

endmodule
